/* filelist.f */
common/isa_pkg.sv
common/dmem_pkg.sv
lsu/lsu_issue.sv
lsu/lsu_load_align.sv
verilog/dmem_ram.sv
verilog/mem_stage.sv
verif/mem_stage_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := mem_stage_tb
FILELIST := filelist.f
LOG      := sim.log
PASS_MSG := Finished with no errors

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verif/mem_stage_tb.sv */
`timescale 1ns/100ps

module mem_stage_tb
    import isa_pkg::*;
    import dmem_pkg::*;
();

    localparam int WAIT_LIMIT = 20;                 // cycles before a wait gives up

    logic       clk;
    logic       rst_n;
    stage_req_t req;
    wb_t        wb;
    int         cycle_cnt = 0;
    word_t      lcg_state = 32'd8188;

    mem_stage dut_i (
        .clk     (clk),
        .rst_n_i (rst_n),
        .req_i   (req),
        .wb_o    (wb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    function automatic word_t rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic reg_addr_t rand_reg();
        word_t w;
        w = rand_word();
        return w[REG_ADDR_W-1:0];
    endfunction

    function automatic word_t rand_word_addr();
        word_t w;
        w = rand_word();
        return word_t'({w[DMEM_ADDR_W+1:2], 2'b00}); // aligned, inside the ram
    endfunction

    // big-endian: offset 0 is bits 31..24
    function automatic logic [7:0] be_byte(word_t w, int off);
        return w[WORD_W-1-8*off -: 8];
    endfunction

    function automatic logic [15:0] be_half(word_t w, int off);
        return w[WORD_W-1-8*off -: 16];
    endfunction

    function automatic word_t insert_byte(word_t w, int off, logic [7:0] b);
        word_t r;
        r = w;
        r[WORD_W-1-8*off -: 8] = b;
        return r;
    endfunction

    function automatic stage_req_t make_req(mem_op_e op, logic wreg, reg_addr_t waddr,
                                            word_t alu, word_t sd);
        stage_req_t r;
        r.valid      = 1'b1;
        r.op         = op;
        r.wreg       = wreg;
        r.waddr      = waddr;
        r.alu_result = alu;
        r.store_data = sd;
        return r;
    endfunction

    task automatic stop_with_error(string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
            stop_with_error("word mismatch");
        end
    endtask

    task automatic check_reg_addr(string name, reg_addr_t exp, reg_addr_t act);
        if (act !== exp) begin
            $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
            stop_with_error("register address mismatch");
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
            stop_with_error("bit mismatch");
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;                                         // inputs move 1 ns after the edge
    endtask

    // waits for wb valid and checks it shows up on the expected cycle
    task automatic wait_wb(int due, string what, output wb_t got);
        int waited;
        waited = 0;
        while (wb.valid !== 1'b1) begin
            if (waited >= WAIT_LIMIT) begin
                stop_with_error($sformatf("timed out waiting for the %s write-back", what));
            end
            step();
            waited++;
        end
        if (cycle_cnt != due) begin
            stop_with_error($sformatf("%s write-back came at cycle %0d instead of %0d",
                                      what, cycle_cnt, due));
        end
        got = wb;
    endtask

    task automatic run_one(stage_req_t r, string what, output wb_t got);
        int due;
        due = cycle_cnt + 3;                        // sampled next edge, wb two edges later
        req = r;
        step();
        req = '0;
        wait_wb(due, what, got);
    endtask

    task automatic do_store(mem_op_e op, word_t addr, word_t data);
        wb_t got;
        run_one(make_req(op, 1'b0, rand_reg(), addr, data), "store", got);
        check_bit("wb_o.we", 1'b0, got.we);
    endtask

    // any op that writes rt, sc included
    task automatic check_reg_write(mem_op_e op, word_t addr, word_t sd, word_t exp);
        wb_t       got;
        reg_addr_t rd;
        rd = rand_reg();
        run_one(make_req(op, 1'b1, rd, addr, sd), op.name(), got);
        check_bit("wb_o.we", 1'b1, got.we);
        check_reg_addr("wb_o.waddr", rd, got.waddr);
        check_word("wb_o.wdata", exp, got.wdata);
    endtask

    task automatic check_load(mem_op_e op, word_t addr, word_t exp);
        check_reg_write(op, addr, '0, exp);
    endtask

    task automatic check_no_write(mem_op_e op, word_t addr);
        wb_t got;
        run_one(make_req(op, 1'b1, rand_reg(), addr, '0), "misaligned load", got);
        check_bit("wb_o.we", 1'b0, got.we);
    endtask

    task automatic test_reset_pass();
        wb_t       got;
        reg_addr_t rd;
        word_t     val;
        check_bit("wb_o.valid", 1'b0, wb.valid);
        check_bit("wb_o.we", 1'b0, wb.we);
        for (int i = 0; i < 2; i++) begin
            rd  = rand_reg();
            val = rand_word();
            run_one(make_req(OP_NONE, i == 0, rd, val, rand_word()), "pass", got);
            check_bit("wb_o.we", i == 0, got.we);
            check_reg_addr("wb_o.waddr", rd, got.waddr);
            check_word("wb_o.wdata", val, got.wdata);
        end
    endtask

    task automatic test_word_round_trip();
        word_t addr;
        word_t data;
        addr = rand_word_addr();
        data = rand_word();
        do_store(OP_SW, addr, data);
        check_load(OP_LW, addr, data);
    endtask

    task automatic test_byte_half_lanes();
        word_t      base;
        word_t      addr;
        word_t      sd;
        logic [7:0] b;
        logic [15:0] h;
        base = 32'h8c3d_7e91;                       // mixed sign bytes and halves
        addr = rand_word_addr();
        for (int off = 0; off < 4; off++) begin
            sd = rand_word();
            do_store(OP_SW, addr, base);
            do_store(OP_SB, addr + off, sd);
            check_load(OP_LW, addr, insert_byte(base, off, sd[7:0]));
        end
        for (int off = 0; off < 4; off += 2) begin
            sd = rand_word();
            do_store(OP_SW, addr, base);
            do_store(OP_SH, addr + off, sd);
            check_load(OP_LW, addr,
                       insert_byte(insert_byte(base, off, sd[15:8]), off + 1, sd[7:0]));
        end
        do_store(OP_SW, addr, base);
        for (int off = 0; off < 4; off++) begin
            b = be_byte(base, off);
            check_load(OP_LB, addr + off, {{24{b[7]}}, b});
            check_load(OP_LBU, addr + off, {24'd0, b});
        end
        for (int off = 0; off < 4; off += 2) begin
            h = be_half(base, off);
            check_load(OP_LH, addr + off, {{16{h[15]}}, h});
            check_load(OP_LHU, addr + off, {16'd0, h});
        end
    endtask

    task automatic test_misaligned();
        word_t addr;
        word_t data;
        addr = rand_word_addr();
        data = rand_word();
        do_store(OP_SW, addr, data);
        check_no_write(OP_LH, addr + 1);
        check_no_write(OP_LHU, addr + 3);
        for (int off = 1; off < 4; off++) begin
            check_no_write(OP_LW, addr + off);
        end
        do_store(OP_SH, addr + 1, ~data);
        do_store(OP_SH, addr + 3, ~data);
        do_store(OP_SW, addr + 2, ~data);
        check_load(OP_LW, addr, data);              // memory untouched
    endtask

    task automatic test_ll_sc();
        word_t addr;
        word_t first;
        word_t second;
        word_t third;
        addr   = rand_word_addr();
        first  = rand_word();
        second = rand_word();
        third  = ~second;
        do_store(OP_SW, addr, first);
        check_load(OP_LL, addr, first);
        check_reg_write(OP_SC, addr, second, 32'd1);  // link held, store goes through
        check_load(OP_LW, addr, second);
        check_reg_write(OP_SC, addr, third, 32'd0);   // link cleared by the first sc
        check_load(OP_LW, addr, second);              // memory untouched
    endtask

    task automatic test_back_to_back();
        wb_t       got;
        word_t     addr;
        word_t     data;
        word_t     pass_val;
        reg_addr_t rd;
        reg_addr_t rp;
        int        k;
        addr     = rand_word_addr();
        data     = rand_word();
        pass_val = rand_word();
        rd       = rand_reg();
        rp       = rand_reg();
        k        = cycle_cnt;
        req = make_req(OP_SW, 1'b0, rand_reg(), addr, data);
        step();
        req = make_req(OP_LW, 1'b1, rd, addr, '0);
        step();
        req = make_req(OP_NONE, 1'b1, rp, pass_val, '0);
        step();
        req = '0;
        wait_wb(k + 3, "stream store", got);
        check_bit("wb_o.we", 1'b0, got.we);
        step();
        wait_wb(k + 4, "stream load", got);
        check_bit("wb_o.we", 1'b1, got.we);
        check_reg_addr("wb_o.waddr", rd, got.waddr);
        check_word("wb_o.wdata", data, got.wdata);
        step();
        wait_wb(k + 5, "stream pass", got);
        check_bit("wb_o.we", 1'b1, got.we);
        check_reg_addr("wb_o.waddr", rp, got.waddr);
        check_word("wb_o.wdata", pass_val, got.wdata);
    endtask

    initial begin
        req   = '0;
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_pass();
        test_word_round_trip();
        test_byte_half_lanes();
        test_misaligned();
        test_ll_sc();
        test_back_to_back();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* verilog/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage
    import isa_pkg::*;
    import dmem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  stage_req_t req_i,
    output wb_t        wb_o
);

    dmem_req_t dmem_req;
    pend_t     pend;
    word_t     rdata;

    lsu_issue u_issue (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .req_i      (req_i),
        .dmem_req_o (dmem_req),
        .pend_o     (pend)
    );

    // access happens one edge after issue
    dmem_ram u_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (dmem_req),
        .rdata_o (rdata)
    );

    lsu_load_align u_align (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .pend_i  (pend),
        .rdata_i (rdata),
        .wb_o    (wb_o)
    );

endmodule

/* verilog/dmem_ram.sv */
`timescale 1ns/100ps

module dmem_ram
    import isa_pkg::*;
    import dmem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  dmem_req_t req_i,
    output word_t     rdata_o
);

    word_t mem [DMEM_WORDS];    // byte at lowest address in bits 31..24

    // sel bit i guards bits 8*i+7 .. 8*i
    always_ff @(posedge clk) begin
        if (req_i.ce && req_i.we) begin
            for (int i = 0; i < BYTES_PER_WORD; i++) begin
                if (req_i.sel[i]) begin
                    mem[req_i.addr][8*i +: 8] <= req_i.wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_o <= '0;
        end else if (req_i.ce && !req_i.we) begin
            rdata_o <= mem[req_i.addr];             // full word read
        end
    end

    addr_in_range_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_i.ce |-> (int'(req_i.addr) < DMEM_WORDS));

endmodule

/* lsu/lsu_load_align.sv */
`timescale 1ns/100ps

module lsu_load_align
    import isa_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n_i,
    input  pend_t pend_i,
    input  word_t rdata_i,
    output wb_t   wb_o
);

    pend_t       pend_q;
    word_t       shifted;
    logic [7:0]  byte_f;
    logic [15:0] half_f;
    word_t       wdata;

    // move the addressed byte to bits 31..24, big-endian
    assign shifted = rdata_i << (8 * pend_q.offset);
    assign byte_f  = shifted[WORD_W-1 -: 8];
    assign half_f  = shifted[WORD_W-1 -: 16];

    always_comb begin
        case (pend_q.op)
            OP_LB: begin
                wdata = {{24{byte_f[7]}}, byte_f};
            end
            OP_LBU: begin
                wdata = {24'd0, byte_f};
            end
            OP_LH: begin
                wdata = {{16{half_f[15]}}, half_f};
            end
            OP_LHU: begin
                wdata = {16'd0, half_f};
            end
            OP_LW, OP_LL: begin
                wdata = rdata_i;                    // whole word
            end
            default: begin
                wdata = pend_q.data;                // alu result or sc flag
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_q <= '0;
            wb_o   <= '0;
        end else begin
            pend_q     <= pend_i;                   // lines up with ram read
            wb_o.valid <= pend_q.valid;
            wb_o.we    <= pend_q.we;
            wb_o.waddr <= pend_q.waddr;
            wb_o.wdata <= wdata;
        end
    end

    wb_we_valid_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_o.we |-> wb_o.valid);

endmodule

/* lsu/lsu_issue.sv */
`timescale 1ns/100ps

module lsu_issue
    import isa_pkg::*;
    import dmem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  stage_req_t req_i,
    output dmem_req_t  dmem_req_o,
    output pend_t      pend_o
);

    logic [BYTE_OFF_W-1:0] off;
    logic                  half_ok;
    logic                  word_ok;
    logic                  link_q;
    logic                  link_d;
    byte_sel_t             byte_sel;
    byte_sel_t             half_sel;
    dmem_req_t             dmem_d;
    pend_t                 pend_d;

    assign off      = req_i.alu_result[BYTE_OFF_W-1:0];
    assign half_ok  = ~off[0];
    assign word_ok  = (off == '0);
    assign byte_sel = 4'b1000 >> off;               // offset 0 sits in the top lane
    assign half_sel = off[1] ? 4'b0011 : 4'b1100;

    always_comb begin
        dmem_d        = '0;
        dmem_d.addr   = req_i.alu_result[BYTE_OFF_W +: DMEM_ADDR_W];
        dmem_d.sel    = '1;                         // loads fetch the whole word
        pend_d.valid  = req_i.valid;
        pend_d.op     = req_i.op;
        pend_d.offset = off;
        pend_d.we     = 1'b0;
        pend_d.waddr  = req_i.waddr;
        pend_d.data   = req_i.alu_result;
        link_d        = link_q;
        case (req_i.op)
            OP_LB, OP_LBU: begin
                dmem_d.ce = 1'b1;
                pend_d.we = 1'b1;
            end
            OP_LH, OP_LHU: begin
                dmem_d.ce = half_ok;                // odd address, no access
                pend_d.we = half_ok;
            end
            OP_LW: begin
                dmem_d.ce = word_ok;
                pend_d.we = word_ok;
            end
            OP_LL: begin
                dmem_d.ce = 1'b1;
                pend_d.we = 1'b1;
                link_d    = 1'b1;
            end
            OP_SB: begin
                dmem_d.ce    = 1'b1;
                dmem_d.we    = 1'b1;
                dmem_d.sel   = byte_sel;
                dmem_d.wdata = {4{req_i.store_data[7:0]}};
            end
            OP_SH: begin
                dmem_d.ce    = half_ok;
                dmem_d.we    = half_ok;
                dmem_d.sel   = half_sel;
                dmem_d.wdata = {2{req_i.store_data[15:0]}};
            end
            OP_SW: begin
                dmem_d.ce    = word_ok;
                dmem_d.we    = word_ok;
                dmem_d.wdata = req_i.store_data;
            end
            OP_SC: begin
                // store only while the link from an earlier ll still holds
                dmem_d.ce    = link_q;
                dmem_d.we    = link_q;
                dmem_d.wdata = req_i.store_data;
                pend_d.we    = 1'b1;
                pend_d.data  = word_t'(link_q);    // rt gets 1 or 0
                link_d       = 1'b0;
            end
            default: begin
                pend_d.we = req_i.wreg;             // plain alu result
            end
        endcase
        if (!req_i.valid) begin                     // bubble
            dmem_d.ce = 1'b0;
            dmem_d.we = 1'b0;
            pend_d.we = 1'b0;
            link_d    = link_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dmem_req_o <= '0;
            pend_o     <= '0;
            link_q     <= 1'b0;
        end else begin
            dmem_req_o <= dmem_d;
            pend_o     <= pend_d;
            link_q     <= link_d;
        end
    end

    ce_has_lanes_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(dmem_req_o.ce) |-> (dmem_req_o.sel != '0));

    we_needs_ce_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_req_o.we |-> dmem_req_o.ce);

endmodule

/* common/dmem_pkg.sv */
package dmem_pkg;

    import isa_pkg::*;

    localparam int DMEM_WORDS     = 256;
    localparam int BYTES_PER_WORD = 4;
    localparam int DMEM_ADDR_W    = $clog2(DMEM_WORDS);

    typedef logic [DMEM_ADDR_W-1:0] dmem_addr_t;

    // bit 3 is the lowest byte address, big-endian lane order
    typedef logic [BYTES_PER_WORD-1:0] byte_sel_t;

    typedef struct packed {
        logic       ce;
        logic       we;
        dmem_addr_t addr;   // word index
        byte_sel_t  sel;
        word_t      wdata;
    } dmem_req_t;

endpackage

/* common/isa_pkg.sv */
package isa_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int BYTE_OFF_W = 2;  // byte offset inside a word

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        OP_NONE,  // alu result goes straight to write-back
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_LL,
        OP_SC
    } mem_op_e;

    typedef struct packed {
        logic      valid;
        mem_op_e   op;
        logic      wreg;
        reg_addr_t waddr;
        word_t     alu_result;  // effective address for memory ops
        word_t     store_data;  // rt value
    } stage_req_t;

    typedef struct packed {
        logic      valid;
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_t;

    // carried alongside the ram access until the read word is back
    typedef struct packed {
        logic                  valid;
        mem_op_e               op;
        logic [BYTE_OFF_W-1:0] offset;
        logic                  we;
        reg_addr_t             waddr;
        word_t                 data;  // pass-through or sc result
    } pend_t;

endpackage
